/* Makefile */
# Verilator simulation of the C16/Plus4 memory glue

VERILATOR ?= verilator
TOP       ?= tb_c16_mem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bank_ctrl.sv */
`default_nettype none

module bank_ctrl (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      model_i,
	input  c16_map_pkg::cpu_addr_t    cpu_addr_i,
	input  logic                      cpu_wr_i,
	input  logic                      cpu_rd_i,
	input  logic                      cart_lo_present_i,
	input  logic                      cart_hi_present_i,
	output logic                      cpu_ram_wr_o,
	output c16_map_pkg::cpu_addr_t    ram_raddr_o,
	output c16_map_pkg::rom_slot_t    rom_rslot_o,
	output c16_map_pkg::rom_off_t     rom_roff_o,
	output logic                      rd_req_o,
	output c16_map_pkg::src_t         rd_src_o
);

	c16_map_pkg::byte_t     page;
	logic                   io_page;
	logic                   high_half;
	logic                   model_q;
	c16_map_pkg::bank_t     bank_lo;
	c16_map_pkg::bank_t     bank_hi;
	c16_map_pkg::bank_t     half_bank;
	logic                   half_cart;
	c16_map_pkg::src_t      src_next;
	c16_map_pkg::rom_slot_t slot_next;

	assign page      = cpu_addr_i[15:8];
	assign io_page   = (page >= c16_map_pkg::IO_FIRST_PAGE) && (page <= c16_map_pkg::IO_LAST_PAGE);
	assign high_half = (cpu_addr_i >= c16_map_pkg::ROM_HIGH_BASE);
	assign half_bank = high_half ? bank_hi : bank_lo;
	assign half_cart = high_half ? cart_hi_present_i : cart_lo_present_i;

	// I/O pages never reach RAM
	assign cpu_ram_wr_o = cpu_wr_i && !io_page;

	//////////////////////////////
	// Model and bank latches
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model_i;
			bank_lo <= c16_map_pkg::INTERNAL;
			bank_hi <= c16_map_pkg::INTERNAL;
		end else if (model_q && cpu_wr_i
				&& cpu_addr_i[15:4] == c16_map_pkg::BANK_REG_PREFIX) begin
			bank_lo <= c16_map_pkg::bank_t'(cpu_addr_i[1:0]);
			bank_hi <= c16_map_pkg::bank_t'(cpu_addr_i[3:2]);
		end
	end

	//////////////////////////////
	// Read decode
	//////////////////////////////

	always_comb begin
		src_next  = c16_map_pkg::SRC_ROM;
		slot_next = c16_map_pkg::KERNAL;
		if (io_page) begin
			src_next = c16_map_pkg::SRC_NONE;
		end else if (cpu_addr_i < c16_map_pkg::ROM_LOW_BASE) begin
			src_next = c16_map_pkg::SRC_RAM;
		end else if (page != c16_map_pkg::KERNAL_PAGE) begin
			case (half_bank)
				c16_map_pkg::INTERNAL:
					slot_next = high_half ? c16_map_pkg::KERNAL : c16_map_pkg::BASIC;
				c16_map_pkg::CART: begin
					slot_next = high_half ? c16_map_pkg::CART_HIGH : c16_map_pkg::CART_LOW;
					// No cartridge image means open bus
					if (!half_cart)
						src_next = c16_map_pkg::SRC_NONE;
				end
				c16_map_pkg::FUNC:
					slot_next = high_half ? c16_map_pkg::FUNC_HIGH : c16_map_pkg::FUNC_LOW;
				default:
					src_next = c16_map_pkg::SRC_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_req_o <= 1'b0;
		else
			rd_req_o <= cpu_rd_i;
	end

	always_ff @(posedge clk_sys) begin
		ram_raddr_o <= cpu_addr_i;
		rom_rslot_o <= slot_next;
		rom_roff_o  <= cpu_addr_i[13:0];
		rd_src_o    <= src_next;
	end

endmodule

`default_nettype wire

/* c16_load_pkg.sv */
`default_nettype none

package c16_load_pkg;

	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	// Download kinds
	localparam dl_index_t IDX_ROM  = 8'd0;
	localparam dl_index_t IDX_PRG  = 8'd1;
	localparam dl_index_t IDX_CART = 8'd2;

	// PRG files start with the load address, low byte first
	localparam dl_addr_t PRG_HEADER_LEN = 25'd2;

	// BASIC pointers patched with the end address after a PRG load
	// Even entries take the low byte, odd entries the high byte
	localparam int PTR_COUNT = 8;
	localparam c16_map_pkg::cpu_addr_t PTR_ADDR [PTR_COUNT] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h009D, 16'h009E
	};

	// Slot number field of a ROM download address starts here
	localparam int ROM_SLOT_SHIFT = 14;

endpackage

`default_nettype wire

/* c16_map_pkg.sv */
`default_nettype none

package c16_map_pkg;

	////////////////////////////////
	// Basic data and address types
	////////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] rom_off_t;

	// ROM slot numbers inside the ROM store
	typedef enum logic [2:0] {
		KERNAL    = 3'd0,
		BASIC     = 3'd1,
		FUNC_LOW  = 3'd2,
		FUNC_HIGH = 3'd3,
		CART_LOW  = 3'd4,
		CART_HIGH = 3'd5
	} rom_slot_t;

	localparam int ROM_SLOT_COUNT = 6;

	// Bank code for one half of the 8000-FFFF area
	typedef enum logic [1:0] {
		INTERNAL = 2'd0,
		CART     = 2'd1,
		FUNC     = 2'd2,
		EMPTY    = 2'd3
	} bank_t;

	// Where a CPU read takes its byte from
	typedef enum logic [1:0] {
		SRC_RAM,
		SRC_ROM,
		SRC_NONE
	} src_t;

	////////////////////////////////
	// Memory map
	////////////////////////////////

	localparam cpu_addr_t   ROM_LOW_BASE    = 16'h8000;
	localparam cpu_addr_t   ROM_HIGH_BASE   = 16'hC000;
	localparam byte_t       KERNAL_PAGE     = 8'hFC;
	localparam byte_t       IO_FIRST_PAGE   = 8'hFD;
	localparam byte_t       IO_LAST_PAGE    = 8'hFE;
	localparam logic [11:0] BANK_REG_PREFIX = 12'hFDD;

	// Open bus value
	localparam byte_t NONE_BYTE = 8'hFF;

endpackage

`default_nettype wire

/* c16_mem_top.sv */
`default_nettype none

module c16_mem_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active_i,
	input  c16_load_pkg::dl_index_t   dl_index_i,
	input  logic                      dl_wr_i,
	input  c16_load_pkg::dl_addr_t    dl_addr_i,
	input  c16_map_pkg::byte_t        dl_data_i,
	input  logic                      model_i,
	input  c16_map_pkg::cpu_addr_t    cpu_addr_i,
	input  c16_map_pkg::byte_t        cpu_data_i,
	input  logic                      cpu_wr_i,
	input  logic                      cpu_rd_i,
	output c16_map_pkg::byte_t        cpu_data_o,
	output logic                      cpu_rd_valid_o
);

	logic                   ldr_wr;
	c16_map_pkg::cpu_addr_t ldr_addr;
	c16_map_pkg::byte_t     ldr_data;
	logic                   rom_wr;
	c16_map_pkg::rom_slot_t rom_wslot;
	c16_map_pkg::rom_off_t  rom_woff;
	c16_map_pkg::byte_t     rom_wdata;
	logic                   cart_lo_present;
	logic                   cart_hi_present;
	logic                   cpu_ram_wr;
	c16_map_pkg::cpu_addr_t ram_raddr;
	c16_map_pkg::rom_slot_t rom_rslot;
	c16_map_pkg::rom_off_t  rom_roff;
	logic                   rd_req;
	c16_map_pkg::src_t      rd_src;
	c16_map_pkg::byte_t     ram_q;
	c16_map_pkg::byte_t     rom_q;

	//////////////////////////////
	// Download side
	//////////////////////////////

	prg_loader u_prg_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.ldr_wr_o    (ldr_wr),
		.ldr_addr_o  (ldr_addr),
		.ldr_data_o  (ldr_data)
	);

	rom_loader u_rom_loader (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dl_index_i        (dl_index_i),
		.dl_wr_i           (dl_wr_i),
		.dl_addr_i         (dl_addr_i),
		.dl_data_i         (dl_data_i),
		.rom_wr_o          (rom_wr),
		.rom_wslot_o       (rom_wslot),
		.rom_woff_o        (rom_woff),
		.rom_wdata_o       (rom_wdata),
		.cart_lo_present_o (cart_lo_present),
		.cart_hi_present_o (cart_hi_present)
	);

	//////////////////////////////
	// Banking and memories
	//////////////////////////////

	bank_ctrl u_bank_ctrl (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.model_i           (model_i),
		.cpu_addr_i        (cpu_addr_i),
		.cpu_wr_i          (cpu_wr_i),
		.cpu_rd_i          (cpu_rd_i),
		.cart_lo_present_i (cart_lo_present),
		.cart_hi_present_i (cart_hi_present),
		.cpu_ram_wr_o      (cpu_ram_wr),
		.ram_raddr_o       (ram_raddr),
		.rom_rslot_o       (rom_rslot),
		.rom_roff_o        (rom_roff),
		.rd_req_o          (rd_req),
		.rd_src_o          (rd_src)
	);

	main_ram u_main_ram (
		.clk_sys    (clk_sys),
		.ldr_wr_i   (ldr_wr),
		.ldr_addr_i (ldr_addr),
		.ldr_data_i (ldr_data),
		.cpu_wr_i   (cpu_ram_wr),
		.cpu_addr_i (cpu_addr_i),
		.cpu_data_i (cpu_data_i),
		.raddr_i    (ram_raddr),
		.q_o        (ram_q)
	);

	rom_store u_rom_store (
		.clk_sys (clk_sys),
		.wr_i    (rom_wr),
		.wslot_i (rom_wslot),
		.woff_i  (rom_woff),
		.wdata_i (rom_wdata),
		.rslot_i (rom_rslot),
		.roff_i  (rom_roff),
		.q_o     (rom_q)
	);

	// CPU read result
	read_merge u_read_merge (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.rd_req_i       (rd_req),
		.rd_src_i       (rd_src),
		.ram_q_i        (ram_q),
		.rom_q_i        (rom_q),
		.cpu_data_o     (cpu_data_o),
		.cpu_rd_valid_o (cpu_rd_valid_o)
	);

endmodule

`default_nettype wire

/* main_ram.sv */
`default_nettype none

module main_ram (
	input  logic                      clk_sys,
	input  logic                      ldr_wr_i,
	input  c16_map_pkg::cpu_addr_t    ldr_addr_i,
	input  c16_map_pkg::byte_t        ldr_data_i,
	input  logic                      cpu_wr_i,
	input  c16_map_pkg::cpu_addr_t    cpu_addr_i,
	input  c16_map_pkg::byte_t        cpu_data_i,
	input  c16_map_pkg::cpu_addr_t    raddr_i,
	output c16_map_pkg::byte_t        q_o
);

	localparam int RAM_DEPTH = 2 ** $bits(c16_map_pkg::cpu_addr_t);

	c16_map_pkg::byte_t mem [RAM_DEPTH];

	// Single write port shared by loader and CPU, loader first
	always_ff @(posedge clk_sys) begin
		if (ldr_wr_i)
			mem[ldr_addr_i] <= ldr_data_i;
		else if (cpu_wr_i)
			mem[cpu_addr_i] <= cpu_data_i;
	end

	always_ff @(posedge clk_sys) begin
		q_o <= mem[raddr_i];
	end

endmodule

`default_nettype wire

/* prg_loader.sv */
`default_nettype none

module prg_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active_i,
	input  c16_load_pkg::dl_index_t   dl_index_i,
	input  logic                      dl_wr_i,
	input  c16_load_pkg::dl_addr_t    dl_addr_i,
	input  c16_map_pkg::byte_t        dl_data_i,
	output logic                      ldr_wr_o,
	output c16_map_pkg::cpu_addr_t    ldr_addr_o,
	output c16_map_pkg::byte_t        ldr_data_o
);

	localparam int PATCH_LAST = 2 * c16_load_pkg::PTR_COUNT;

	logic                                     is_prg;
	logic                                     prg_wr;
	logic                                     hdr_wr;
	logic                                     byte_wr;
	logic                                     patch_wr;
	logic                                     dl_active_q;
	logic [$clog2(PATCH_LAST+1)-1:0]          patch_step;
	logic [$clog2(c16_load_pkg::PTR_COUNT)-1:0] patch_idx;
	c16_map_pkg::cpu_addr_t                   run_addr;

	assign is_prg  = (dl_index_i == c16_load_pkg::IDX_PRG);
	assign prg_wr  = dl_active_i && dl_wr_i && is_prg;
	assign hdr_wr  = prg_wr && (dl_addr_i < c16_load_pkg::PRG_HEADER_LEN);
	assign byte_wr = prg_wr && !hdr_wr;

	// Odd steps write, even steps leave a gap
	assign patch_wr  = patch_step[0];
	assign patch_idx = patch_step[$clog2(c16_load_pkg::PTR_COUNT):1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			patch_step  <= '0;
			ldr_wr_o    <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			ldr_wr_o    <= byte_wr || patch_wr;
			if (dl_active_q && !dl_active_i && is_prg) begin
				patch_step <= 1'b1;
			end else if (patch_step == PATCH_LAST) begin
				patch_step <= '0;
			end else if (patch_step != '0) begin
				patch_step <= patch_step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (patch_wr) begin
			ldr_addr_o <= c16_load_pkg::PTR_ADDR[patch_idx];
			ldr_data_o <= patch_idx[0] ? run_addr[15:8] : run_addr[7:0];
		end else if (byte_wr) begin
			ldr_addr_o <= run_addr;
			ldr_data_o <= dl_data_i;
		end

		// Running address, loaded from the header and stepped per byte
		if (hdr_wr) begin
			if (dl_addr_i[0])
				run_addr[15:8] <= dl_data_i;
			else
				run_addr[7:0] <= dl_data_i;
		end else if (byte_wr) begin
			run_addr <= run_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* read_merge.sv */
`default_nettype none

module read_merge (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      rd_req_i,
	input  c16_map_pkg::src_t         rd_src_i,
	input  c16_map_pkg::byte_t        ram_q_i,
	input  c16_map_pkg::byte_t        rom_q_i,
	output c16_map_pkg::byte_t        cpu_data_o,
	output logic                      cpu_rd_valid_o
);

	logic              req_q;
	c16_map_pkg::src_t src_q;

	// One stage to line up with the memory read registers
	always_ff @(posedge clk_sys) begin
		if (reset)
			req_q <= 1'b0;
		else
			req_q <= rd_req_i;
	end

	always_ff @(posedge clk_sys) begin
		src_q <= rd_src_i;
	end

	assign cpu_rd_valid_o = req_q;

	always_comb begin
		case (src_q)
			c16_map_pkg::SRC_RAM: cpu_data_o = ram_q_i;
			c16_map_pkg::SRC_ROM: cpu_data_o = rom_q_i;
			default:              cpu_data_o = c16_map_pkg::NONE_BYTE;
		endcase
	end

endmodule

`default_nettype wire

/* rom_loader.sv */
`default_nettype none

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  c16_load_pkg::dl_index_t   dl_index_i,
	input  logic                      dl_wr_i,
	input  c16_load_pkg::dl_addr_t    dl_addr_i,
	input  c16_map_pkg::byte_t        dl_data_i,
	output logic                      rom_wr_o,
	output c16_map_pkg::rom_slot_t    rom_wslot_o,
	output c16_map_pkg::rom_off_t     rom_woff_o,
	output c16_map_pkg::byte_t        rom_wdata_o,
	output logic                      cart_lo_present_o,
	output logic                      cart_hi_present_o
);

	localparam int SLOT_W = $bits(c16_load_pkg::dl_addr_t) - c16_load_pkg::ROM_SLOT_SHIFT;

	logic [SLOT_W-1:0]      dl_slot;
	logic                   slot_hit;
	logic                   slot_wr;
	c16_map_pkg::rom_slot_t slot_sel;

	assign dl_slot = dl_addr_i[$bits(c16_load_pkg::dl_addr_t)-1:c16_load_pkg::ROM_SLOT_SHIFT];
	assign slot_wr = dl_wr_i && slot_hit;

	// Map download kind and slot number onto a ROM slot
	always_comb begin
		slot_hit = 1'b1;
		slot_sel = c16_map_pkg::KERNAL;
		if (dl_index_i == c16_load_pkg::IDX_ROM) begin
			case (dl_slot)
				1:       slot_sel = c16_map_pkg::KERNAL;
				2:       slot_sel = c16_map_pkg::BASIC;
				3:       slot_sel = c16_map_pkg::FUNC_LOW;
				4:       slot_sel = c16_map_pkg::FUNC_HIGH;
				default: slot_hit = 1'b0;
			endcase
		end else if (dl_index_i == c16_load_pkg::IDX_CART) begin
			case (dl_slot)
				0:       slot_sel = c16_map_pkg::CART_LOW;
				1:       slot_sel = c16_map_pkg::CART_HIGH;
				default: slot_hit = 1'b0;
			endcase
		end else begin
			slot_hit = 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_wr_o          <= 1'b0;
			cart_lo_present_o <= 1'b0;
			cart_hi_present_o <= 1'b0;
		end else begin
			rom_wr_o <= slot_wr;
			// Present flags stick until the next reset
			if (slot_wr && slot_sel == c16_map_pkg::CART_LOW)
				cart_lo_present_o <= 1'b1;
			if (slot_wr && slot_sel == c16_map_pkg::CART_HIGH)
				cart_hi_present_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		rom_wslot_o <= slot_sel;
		rom_woff_o  <= dl_addr_i[c16_load_pkg::ROM_SLOT_SHIFT-1:0];
		rom_wdata_o <= dl_data_i;
	end

endmodule

`default_nettype wire

/* rom_store.sv */
`default_nettype none

module rom_store (
	input  logic                      clk_sys,
	input  logic                      wr_i,
	input  c16_map_pkg::rom_slot_t    wslot_i,
	input  c16_map_pkg::rom_off_t     woff_i,
	input  c16_map_pkg::byte_t        wdata_i,
	input  c16_map_pkg::rom_slot_t    rslot_i,
	input  c16_map_pkg::rom_off_t     roff_i,
	output c16_map_pkg::byte_t        q_o
);

	localparam int SLOT_SIZE = 2 ** $bits(c16_map_pkg::rom_off_t);
	localparam int ROM_DEPTH = c16_map_pkg::ROM_SLOT_COUNT * SLOT_SIZE;

	// Slot number forms the upper address bits
	c16_map_pkg::byte_t mem [ROM_DEPTH];

	initial begin
		for (int i = 0; i < ROM_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_i)
			mem[{wslot_i, woff_i}] <= wdata_i;
		q_o <= mem[{rslot_i, roff_i}];
	end

endmodule

`default_nettype wire

/* src.f */
c16_map_pkg.sv
c16_load_pkg.sv
prg_loader.sv
rom_loader.sv
bank_ctrl.sv
main_ram.sv
rom_store.sv
read_merge.sv
c16_mem_top.sv
tb_c16_mem.sv

/* tb_c16_mem.sv */
`default_nettype none

module tb_c16_mem;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int          HALF_PERIOD      = 50;
	localparam int          RESET_CYCLES     = 5;
	localparam int          PATCH_CYCLES     = 18;
	localparam int          READ_LATENCY     = 2;
	localparam int          CYCLES_PER_ENTRY = 40;
	localparam int          PRG_LEN          = 6;
	localparam int unsigned SEED             = 32'h37009ff9;

	localparam c16_map_pkg::cpu_addr_t LOAD_ADDR = 16'h1001;
	localparam c16_map_pkg::cpu_addr_t END_ADDR  = LOAD_ADDR + 16'(PRG_LEN);

	// Marker bytes placed in the ROM images
	localparam c16_map_pkg::byte_t KERNAL_0000 = 8'h4B;
	localparam c16_map_pkg::byte_t KERNAL_3C10 = 8'h4C;
	localparam c16_map_pkg::byte_t BASIC_0000  = 8'h42;
	localparam c16_map_pkg::byte_t FLO_0000    = 8'h46;
	localparam c16_map_pkg::byte_t FHI_0000    = 8'h66;
	localparam c16_map_pkg::byte_t CLO_0000    = 8'h63;
	localparam c16_map_pkg::byte_t CHI_0000    = 8'h43;
	localparam c16_map_pkg::byte_t RAM_2000    = 8'h5A;

	typedef enum int {
		K_RESET,
		K_DL_BYTE,
		K_DL_END,
		K_CPU_WR,
		K_CPU_RD,
		K_CPU_RD_NEXT
	} entry_kind_t;

	logic                      clk_sys;
	logic                      reset;
	logic                      dl_active_i;
	c16_load_pkg::dl_index_t   dl_index_i;
	logic                      dl_wr_i;
	c16_load_pkg::dl_addr_t    dl_addr_i;
	c16_map_pkg::byte_t        dl_data_i;
	logic                      model_i;
	c16_map_pkg::cpu_addr_t    cpu_addr_i;
	c16_map_pkg::byte_t        cpu_data_i;
	logic                      cpu_wr_i;
	logic                      cpu_rd_i;
	c16_map_pkg::byte_t        cpu_data_o;
	logic                      cpu_rd_valid_o;

	int                        cycle_cnt;
	int                        cycle_limit;
	logic                      table_ready;
	c16_map_pkg::byte_t        prg_bytes [PRG_LEN];

	// Stimulus table, one entry per index
	entry_kind_t               tbl_kind [$];
	c16_load_pkg::dl_index_t   tbl_idx [$];
	c16_load_pkg::dl_addr_t    tbl_addr [$];
	c16_map_pkg::byte_t        tbl_data [$];
	c16_map_pkg::byte_t        tbl_exp [$];
	string                     tbl_name [$];

	// Reads in flight
	int                        pend_cycle [$];
	c16_map_pkg::byte_t        pend_exp [$];
	string                     pend_name [$];

	c16_mem_top uut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.model_i        (model_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_data_i     (cpu_data_i),
		.cpu_wr_i       (cpu_wr_i),
		.cpu_rd_i       (cpu_rd_i),
		.cpu_data_o     (cpu_data_o),
		.cpu_rd_valid_o (cpu_rd_valid_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Cycle counter and watchdog
	initial begin
		cycle_cnt = 0;
		wait (table_ready);
		cycle_limit = CYCLES_PER_ENTRY * tbl_kind.size();
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk_sys);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("Timeout: the test did not finish within %0d clock cycles", cycle_limit);
		stop_on_failure();
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic stop_on_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input c16_map_pkg::byte_t exp,
			input c16_map_pkg::byte_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %02h, actual %02h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected valid %b, actual valid %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	// Advance to the next falling edge and check the read port there
	task automatic next_cycle();
		string name;
		logic  exp_valid;
		@(negedge clk_sys);
		name      = "no read pending";
		exp_valid = 1'b0;
		if (pend_cycle.size() > 0) begin
			name      = pend_name[0];
			exp_valid = (pend_cycle[0] + READ_LATENCY == cycle_cnt);
		end
		if (!reset)
			check_valid(name, exp_valid, cpu_rd_valid_o);
		if (exp_valid) begin
			check_byte(name, pend_exp[0], cpu_data_o);
			void'(pend_cycle.pop_front());
			void'(pend_exp.pop_front());
			void'(pend_name.pop_front());
		end
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic do_reset(input logic model);
		reset       = 1'b1;
		model_i     = model;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		cpu_wr_i    = 1'b0;
		cpu_rd_i    = 1'b0;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	// One strobe, then a gap cycle
	task automatic send_dl_byte(input c16_load_pkg::dl_index_t idx,
			input c16_load_pkg::dl_addr_t addr, input c16_map_pkg::byte_t data);
		dl_active_i = 1'b1;
		dl_index_i  = idx;
		dl_addr_i   = addr;
		dl_data_i   = data;
		dl_wr_i     = 1'b1;
		next_cycle();
		dl_wr_i = 1'b0;
		next_cycle();
	endtask

	// Index is held so a PRG download ends with the pointer patch
	task automatic end_download();
		dl_active_i = 1'b0;
		repeat (PATCH_CYCLES) next_cycle();
	endtask

	task automatic cpu_write(input c16_map_pkg::cpu_addr_t addr, input c16_map_pkg::byte_t data);
		cpu_addr_i = addr;
		cpu_data_i = data;
		cpu_wr_i   = 1'b1;
		next_cycle();
		cpu_wr_i = 1'b0;
	endtask

	task automatic issue_read(input c16_map_pkg::cpu_addr_t addr, input c16_map_pkg::byte_t exp,
			input string name);
		cpu_addr_i = addr;
		cpu_rd_i   = 1'b1;
		pend_cycle.push_back(cycle_cnt);
		pend_exp.push_back(exp);
		pend_name.push_back(name);
		next_cycle();
		cpu_rd_i = 1'b0;
	endtask

	task automatic drain_reads();
		while (pend_cycle.size() != 0)
			next_cycle();
	endtask

	task automatic apply_entry(input int i);
		case (tbl_kind[i])
			K_RESET:       do_reset(tbl_idx[i][0]);
			K_DL_BYTE:     send_dl_byte(tbl_idx[i], tbl_addr[i], tbl_data[i]);
			K_DL_END:      end_download();
			K_CPU_WR:      cpu_write(tbl_addr[i][15:0], tbl_data[i]);
			K_CPU_RD: begin
				issue_read(tbl_addr[i][15:0], tbl_exp[i], tbl_name[i]);
				drain_reads();
			end
			default:       issue_read(tbl_addr[i][15:0], tbl_exp[i], tbl_name[i]);
		endcase
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic add_entry(input entry_kind_t kind, input c16_load_pkg::dl_index_t idx,
			input c16_load_pkg::dl_addr_t addr, input c16_map_pkg::byte_t data,
			input c16_map_pkg::byte_t exp, input string name);
		tbl_kind.push_back(kind);
		tbl_idx.push_back(idx);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
		tbl_exp.push_back(exp);
		tbl_name.push_back(name);
	endtask

	// Slot number sits above the 16 KiB offset
	function automatic c16_load_pkg::dl_addr_t rom_dl_addr(input int slot, input int off);
		return (c16_load_pkg::dl_addr_t'(slot) << c16_load_pkg::ROM_SLOT_SHIFT)
			| c16_load_pkg::dl_addr_t'(off);
	endfunction

	task automatic build_table();
		c16_map_pkg::cpu_addr_t rd_addr;
		c16_map_pkg::byte_t     ptr_exp;
		add_entry(K_RESET, 8'd1, '0, '0, '0, "reset plus4");

		// ROM images, slot numbers 1 to 4
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_ROM, rom_dl_addr(1, 0), KERNAL_0000, '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_ROM, rom_dl_addr(1, 'h3C10), KERNAL_3C10, '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_ROM, rom_dl_addr(2, 0), BASIC_0000, '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_ROM, rom_dl_addr(3, 0), FLO_0000, '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_ROM, rom_dl_addr(4, 0), FHI_0000, '0, "");
		add_entry(K_DL_END, c16_load_pkg::IDX_ROM, '0, '0, '0, "");

		// PRG with load address header
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_PRG, 25'd0, LOAD_ADDR[7:0], '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_PRG, 25'd1, LOAD_ADDR[15:8], '0, "");
		for (int b = 0; b < PRG_LEN; b++)
			add_entry(K_DL_BYTE, c16_load_pkg::IDX_PRG, 25'(b + 2), prg_bytes[b], '0, "");
		add_entry(K_DL_END, c16_load_pkg::IDX_PRG, '0, '0, '0, "");

		for (int b = 0; b < PRG_LEN; b++) begin
			rd_addr = LOAD_ADDR + 16'(b);
			add_entry(K_CPU_RD, '0, {9'd0, rd_addr}, '0, prg_bytes[b],
				$sformatf("prg byte %04h", rd_addr));
		end
		for (int p = 0; p < c16_load_pkg::PTR_COUNT; p++) begin
			ptr_exp = p[0] ? END_ADDR[15:8] : END_ADDR[7:0];
			add_entry(K_CPU_RD, '0, {9'd0, c16_load_pkg::PTR_ADDR[p]}, '0, ptr_exp,
				$sformatf("basic pointer %0d", p));
		end

		// Default map
		add_entry(K_CPU_RD, '0, 25'h08000, '0, BASIC_0000, "default 8000");
		add_entry(K_CPU_RD, '0, 25'h0C000, '0, KERNAL_0000, "default c000");
		add_entry(K_CPU_RD, '0, 25'h0FC10, '0, KERNAL_3C10, "default fc10");
		add_entry(K_CPU_RD, '0, 25'h0FD40, '0, 8'hFF, "default fd40");
		add_entry(K_CPU_WR, '0, 25'h02000, RAM_2000, '0, "");
		add_entry(K_CPU_RD, '0, 25'h02000, '0, RAM_2000, "ram 2000");

		// Plus4 banking
		add_entry(K_CPU_WR, '0, 25'h0FDDA, 8'h00, '0, "");
		add_entry(K_CPU_RD, '0, 25'h08000, '0, FLO_0000, "func 8000");
		add_entry(K_CPU_RD, '0, 25'h0C000, '0, FHI_0000, "func c000");
		add_entry(K_CPU_RD, '0, 25'h0FC10, '0, KERNAL_3C10, "func fc10");
		add_entry(K_CPU_WR, '0, 25'h0FDDF, 8'h00, '0, "");
		add_entry(K_CPU_RD, '0, 25'h08000, '0, 8'hFF, "empty 8000");
		add_entry(K_CPU_WR, '0, 25'h0FDD5, 8'h00, '0, "");
		add_entry(K_CPU_RD, '0, 25'h08000, '0, 8'hFF, "no cart 8000");
		add_entry(K_CPU_RD, '0, 25'h0C000, '0, 8'hFF, "no cart c000");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_CART, rom_dl_addr(0, 0), CLO_0000, '0, "");
		add_entry(K_DL_BYTE, c16_load_pkg::IDX_CART, rom_dl_addr(1, 0), CHI_0000, '0, "");
		add_entry(K_DL_END, c16_load_pkg::IDX_CART, '0, '0, '0, "");
		add_entry(K_CPU_RD, '0, 25'h08000, '0, CLO_0000, "cart 8000");
		add_entry(K_CPU_RD, '0, 25'h0C000, '0, CHI_0000, "cart c000");

		// Reads on consecutive cycles, mixing RAM, ROM and open bus
		add_entry(K_CPU_RD_NEXT, '0, 25'h01001, '0, prg_bytes[0], "burst 1001");
		add_entry(K_CPU_RD_NEXT, '0, 25'h01002, '0, prg_bytes[1], "burst 1002");
		add_entry(K_CPU_RD_NEXT, '0, 25'h08000, '0, CLO_0000, "burst 8000");
		add_entry(K_CPU_RD_NEXT, '0, 25'h0C000, '0, CHI_0000, "burst c000");
		add_entry(K_CPU_RD_NEXT, '0, 25'h0FD40, '0, 8'hFF, "burst fd40");
		add_entry(K_CPU_RD_NEXT, '0, 25'h0FC10, '0, KERNAL_3C10, "burst fc10");
		add_entry(K_CPU_RD, '0, 25'h02000, '0, RAM_2000, "burst 2000");

		// C16 ignores bank writes
		add_entry(K_RESET, 8'd0, '0, '0, '0, "reset c16");
		add_entry(K_CPU_WR, '0, 25'h0FDDA, 8'h00, '0, "");
		add_entry(K_CPU_RD, '0, 25'h08000, '0, BASIC_0000, "c16 8000");
		add_entry(K_CPU_RD, '0, 25'h0C000, '0, KERNAL_0000, "c16 c000");
		add_entry(K_CPU_RD, '0, 25'h02000, '0, RAM_2000, "c16 ram 2000");
	endtask

	initial begin
		table_ready = 1'b0;
		reset       = 1'b1;
		model_i     = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = c16_load_pkg::IDX_ROM;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		cpu_addr_i  = '0;
		cpu_data_i  = '0;
		cpu_wr_i    = 1'b0;
		cpu_rd_i    = 1'b0;

		void'($urandom(SEED));
		for (int b = 0; b < PRG_LEN; b++)
			prg_bytes[b] = c16_map_pkg::byte_t'($urandom());
		build_table();
		table_ready = 1'b1;

		for (int i = 0; i < tbl_kind.size(); i++)
			apply_entry(i);
		drain_reads();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
